// File: project.f
source/hpsdr_pkg.sv
source/iq_sample_fifo.sv
source/cmd_response.sv
source/upstream_packer.sv
source/udp_tx_framer.sv
source/hpsdr_upstream_top.sv
verification/tb_hpsdr_upstream.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the upstream testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_hpsdr_upstream -f project.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation FAILED" sim.log; then
  echo "run_sim: failure reported"
  exit 1
fi
echo "run_sim: done"

// File: source/cmd_response.sv
// Command capture that forms the echoed response field for data frames
`timescale 1ns/10ps

module cmd_response (
  input  logic                 clk,
  input  logic                 rst_n,
  input  hpsdr_pkg::cmd_addr_t cmd_addr,
  input  hpsdr_pkg::cmd_data_t cmd_data,
  input  logic                 cmd_rqst,
  input  logic                 resp_rqst,
  output hpsdr_pkg::resp_t     resp
);

  logic                 ack;
  logic                 rqst_d;
  logic                 rqst_edge;
  hpsdr_pkg::cmd_addr_t addr_q;
  hpsdr_pkg::cmd_data_t data_q;

  // Packer toggles resp_rqst after each response field
  assign rqst_edge = resp_rqst ^ rqst_d;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack    <= 1'b0;
      rqst_d <= 1'b0;
      addr_q <= '0;
      data_q <= '0;
    end else begin
      rqst_d <= resp_rqst;
      if (cmd_rqst) begin
        ack    <= 1'b1;
        addr_q <= cmd_addr;
        data_q <= cmd_data;
      end else if (rqst_edge) begin
        // Acknowledged once, later fields repeat the command without it
        ack <= 1'b0;
      end
    end
  end

  assign resp = {ack, 1'b0, addr_q, data_q};

endmodule

// File: source/hpsdr_pkg.sv
// Shared types, frame constants and packer states for the upstream path
package hpsdr_pkg;

  typedef logic [23:0] sample_t;
  typedef logic [7:0]  byte_t;
  typedef logic [10:0] frame_len_t;
  typedef logic [31:0] seq_t;
  typedef logic [47:0] mac_t;

  // Ack byte on top of 32 data bits
  typedef logic [39:0] resp_t;

  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  localparam frame_len_t DISC_LEN  = 11'd60;
  localparam frame_len_t DATA_LEN  = 11'd1032;
  localparam frame_len_t BLOCK_LEN = 11'd512;

  // Fill that must be exceeded before a data frame may start
  localparam frame_len_t MIN_FRAME_WORDS = 11'd334;

  typedef enum logic [3:0] {
    IDLE,
    DISC_REQ,
    DISC_SEND,
    DATA_REQ,
    DATA_HDR,
    SYNC_RESP,
    RX2,
    RX1,
    RX0,
    MIC1,
    MIC0,
    PAD
  } packer_state_t;

endpackage

// File: source/hpsdr_upstream_top.sv
// Upstream top joining sample FIFO, command echo, packer and transmit framer
`timescale 1ns/10ps

module hpsdr_upstream_top #(
  parameter hpsdr_pkg::byte_t NR        = 8'd4,
  parameter hpsdr_pkg::byte_t SERIAL_NO = 8'd0,
  parameter int               FIFO_AW   = 10
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  hpsdr_pkg::sample_t   s_tdata,
  input  logic                 s_tlast,
  input  logic                 s_tvalid,
  output logic                 s_tready,
  input  hpsdr_pkg::cmd_addr_t cmd_addr,
  input  hpsdr_pkg::cmd_data_t cmd_data,
  input  logic                 cmd_rqst,
  input  logic                 run,
  input  logic                 have_ip,
  input  logic                 discovery,
  input  logic                 idhermeslite,
  input  hpsdr_pkg::mac_t      mac,
  output hpsdr_pkg::byte_t     m_tdata,
  output logic                 m_tvalid,
  output logic                 m_tlast,
  input  logic                 m_tready
);

  hpsdr_pkg::sample_t    us_tdata;
  logic                  us_tlast;
  logic                  us_tvalid;
  logic                  us_tready;
  hpsdr_pkg::frame_len_t us_tlength;
  hpsdr_pkg::resp_t      resp;
  logic                  resp_rqst;
  logic                  udp_tx_request;
  logic                  udp_tx_enable;
  hpsdr_pkg::frame_len_t udp_tx_length;
  hpsdr_pkg::byte_t      udp_tx_data;

  iq_sample_fifo #(.FIFO_AW(FIFO_AW)) u_fifo (
    .clk, .rst_n, .s_tdata, .s_tlast, .s_tvalid, .s_tready,
    .us_tdata, .us_tlast, .us_tvalid, .us_tready, .us_tlength
  );

  cmd_response u_cmd (
    .clk, .rst_n, .cmd_addr, .cmd_data, .cmd_rqst, .resp_rqst, .resp
  );

  upstream_packer #(.NR(NR), .SERIAL_NO(SERIAL_NO)) u_packer (
    .clk, .rst_n, .run, .have_ip, .discovery, .idhermeslite, .mac,
    .udp_tx_enable, .udp_tx_request, .udp_tx_length, .udp_tx_data,
    .us_tdata, .us_tlast, .us_tvalid, .us_tready, .us_tlength,
    .resp, .resp_rqst
  );

  udp_tx_framer u_framer (
    .clk, .rst_n, .udp_tx_request, .udp_tx_length, .udp_tx_data,
    .udp_tx_enable, .m_tdata, .m_tvalid, .m_tlast, .m_tready
  );

endmodule

// File: source/iq_sample_fifo.sv
// Sample FIFO holding IQ words with their round-end flag and reporting its fill
`timescale 1ns/10ps

module iq_sample_fifo #(
  parameter int FIFO_AW = 10
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  hpsdr_pkg::sample_t    s_tdata,
  input  logic                  s_tlast,
  input  logic                  s_tvalid,
  output logic                  s_tready,
  output hpsdr_pkg::sample_t    us_tdata,
  output logic                  us_tlast,
  output logic                  us_tvalid,
  input  logic                  us_tready,
  output hpsdr_pkg::frame_len_t us_tlength
);

  localparam int unsigned DEPTH = 2 ** FIFO_AW;

  // Entry is {last, sample}
  logic [24:0]        mem [0:DEPTH-1];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               push;
  logic               pop;

  assign s_tready  = (count != (FIFO_AW+1)'(DEPTH));
  assign us_tvalid = (count != '0);
  assign push      = s_tvalid && s_tready;
  assign pop       = us_tready && us_tvalid;

  // Head entry shown without a read cycle
  assign us_tdata   = mem[rd_ptr][23:0];
  assign us_tlast   = mem[rd_ptr][24];
  assign us_tlength = hpsdr_pkg::frame_len_t'(count);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {s_tlast, s_tdata};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Packer only pops a word that is there
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    us_tready |-> count != '0);

endmodule

// File: source/udp_tx_framer.sv
// Transmit framer granting packer requests and emitting a valid/last byte stream
`timescale 1ns/10ps

module udp_tx_framer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  udp_tx_request,
  input  hpsdr_pkg::frame_len_t udp_tx_length,
  input  hpsdr_pkg::byte_t      udp_tx_data,
  output logic                  udp_tx_enable,
  output hpsdr_pkg::byte_t      m_tdata,
  output logic                  m_tvalid,
  output logic                  m_tlast,
  input  logic                  m_tready
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_GRANT,
    TX_SEND
  } framer_state_t;

  framer_state_t         state;
  hpsdr_pkg::frame_len_t len_q;
  hpsdr_pkg::frame_len_t cnt;

  assign udp_tx_enable = (state == TX_GRANT);

  // Packer updates its byte register every cycle of the frame
  assign m_tdata = udp_tx_data;

  always_ff @(posedge clk) begin
    if (state == TX_IDLE) begin
      len_q <= udp_tx_length;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= TX_IDLE;
      cnt      <= '0;
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (udp_tx_request && m_tready) state <= TX_GRANT;
        end
        TX_GRANT: begin
          state    <= TX_SEND;
          cnt      <= 11'd1;
          m_tvalid <= 1'b1;
          m_tlast  <= (len_q == 11'd1);
        end
        TX_SEND: begin
          if (m_tlast) begin
            state    <= TX_IDLE;
            m_tvalid <= 1'b0;
            m_tlast  <= 1'b0;
          end else begin
            cnt     <= cnt + 11'd1;
            m_tlast <= (cnt + 11'd1 == len_q);
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Downstream committed to the frame once it was granted
  a_ready_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    state == TX_SEND |-> m_tready);

endmodule

// File: source/upstream_packer.sv
// Upstream packer building discovery replies and 1032-byte IQ data frames
`timescale 1ns/10ps

module upstream_packer #(
  parameter hpsdr_pkg::byte_t NR        = 8'd4,
  parameter hpsdr_pkg::byte_t SERIAL_NO = 8'd0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,
  input  logic                  have_ip,
  input  logic                  discovery,
  input  logic                  idhermeslite,
  input  hpsdr_pkg::mac_t       mac,
  input  logic                  udp_tx_enable,
  output logic                  udp_tx_request,
  output hpsdr_pkg::frame_len_t udp_tx_length,
  output hpsdr_pkg::byte_t      udp_tx_data,
  input  hpsdr_pkg::sample_t    us_tdata,
  input  logic                  us_tlast,
  input  logic                  us_tvalid,
  output logic                  us_tready,
  input  hpsdr_pkg::frame_len_t us_tlength,
  input  hpsdr_pkg::resp_t      resp,
  output logic                  resp_rqst
);

  hpsdr_pkg::packer_state_t state, state_next, blk_exit;
  hpsdr_pkg::frame_len_t    byte_no, byte_no_next, len_next, pos;
  hpsdr_pkg::byte_t         data_next;
  hpsdr_pkg::seq_t          seq, seq_next;
  logic [8:0]               round_len, round_len_next, blk_pos;
  logic                     resp_rqst_next;
  logic                     disc_pend;
  logic                     start_data;
  logic                     blk_end;
  logic                     in_block;

  // byte_no counts the bytes left after the one being loaded
  assign pos      = udp_tx_length - 11'd1 - byte_no;
  assign blk_pos  = 9'(hpsdr_pkg::BLOCK_LEN - 11'd1) - byte_no[8:0];
  assign blk_end  = (byte_no[8:0] == 9'd0);
  assign blk_exit = byte_no[9] ? hpsdr_pkg::SYNC_RESP : hpsdr_pkg::IDLE;

  assign start_data = run && have_ip && us_tvalid &&
                      (us_tlength > hpsdr_pkg::MIN_FRAME_WORDS);

  assign udp_tx_request = (state == hpsdr_pkg::DISC_REQ) || (state == hpsdr_pkg::DATA_REQ);
  assign us_tready      = (state == hpsdr_pkg::RX0);
  assign in_block       = state inside {hpsdr_pkg::RX2, hpsdr_pkg::RX1, hpsdr_pkg::RX0,
                                        hpsdr_pkg::MIC1, hpsdr_pkg::MIC0, hpsdr_pkg::PAD};

  always_comb begin
    state_next     = state;
    byte_no_next   = byte_no;
    data_next      = udp_tx_data;
    len_next       = udp_tx_length;
    seq_next       = seq;
    round_len_next = round_len;
    resp_rqst_next = resp_rqst;

    case (state)
      hpsdr_pkg::IDLE: begin
        if (disc_pend || discovery) begin
          len_next   = hpsdr_pkg::DISC_LEN;
          state_next = hpsdr_pkg::DISC_REQ;
        end else if (start_data) begin
          len_next   = hpsdr_pkg::DATA_LEN;
          state_next = hpsdr_pkg::DATA_REQ;
        end
      end

      hpsdr_pkg::DISC_REQ: begin
        data_next    = 8'hef;
        byte_no_next = hpsdr_pkg::DISC_LEN - 11'd2;
        if (udp_tx_enable) state_next = hpsdr_pkg::DISC_SEND;
      end

      hpsdr_pkg::DISC_SEND: begin
        byte_no_next = byte_no - 11'd1;
        case (pos)
          11'd1:   data_next = 8'hfe;
          11'd2:   data_next = run ? 8'h03 : 8'h02;
          11'd3:   data_next = mac[47:40];
          11'd4:   data_next = mac[39:32];
          11'd5:   data_next = mac[31:24];
          11'd6:   data_next = mac[23:16];
          11'd7:   data_next = mac[15:8];
          11'd8:   data_next = mac[7:0];
          11'd9:   data_next = SERIAL_NO;
          11'd10:  data_next = "H";
          11'd11:  data_next = "E";
          11'd12:  data_next = "R";
          11'd13:  data_next = "M";
          11'd14:  data_next = "E";
          11'd15:  data_next = "S";
          11'd16:  data_next = "L";
          11'd17:  data_next = "T";
          11'd18:  data_next = NR;
          default: data_next = idhermeslite ? 8'h06 : 8'h01;
        endcase
        if (byte_no == '0) state_next = hpsdr_pkg::IDLE;
      end

      hpsdr_pkg::DATA_REQ: begin
        data_next    = 8'hef;
        byte_no_next = hpsdr_pkg::DATA_LEN - 11'd2;
        if (udp_tx_enable) state_next = hpsdr_pkg::DATA_HDR;
      end

      hpsdr_pkg::DATA_HDR: begin
        byte_no_next = byte_no - 11'd1;
        case (pos[2:0])
          3'd1:    data_next = 8'hfe;
          3'd2:    data_next = 8'h01;
          3'd3:    data_next = 8'h06;
          3'd4:    data_next = seq[31:24];
          3'd5:    data_next = seq[23:16];
          3'd6:    data_next = seq[15:8];
          3'd7: begin
            data_next  = seq[7:0];
            seq_next   = seq + 32'd1;
            state_next = hpsdr_pkg::SYNC_RESP;
          end
          default: data_next = 8'h00;
        endcase
      end

      hpsdr_pkg::SYNC_RESP: begin
        byte_no_next   = byte_no - 11'd1;
        round_len_next = '0;
        case (blk_pos)
          9'd0, 9'd1, 9'd2: data_next = 8'h7f;
          9'd3:    data_next = resp[39:32];
          9'd4:    data_next = resp[31:24];
          9'd5:    data_next = resp[23:16];
          9'd6:    data_next = resp[15:8];
          9'd7: begin
            data_next      = resp[7:0];
            resp_rqst_next = ~resp_rqst;
            state_next     = hpsdr_pkg::RX2;
          end
          default: data_next = 8'h00;
        endcase
      end

      hpsdr_pkg::RX2: begin
        byte_no_next   = byte_no - 11'd1;
        round_len_next = round_len + 9'd1;
        data_next      = us_tdata[23:16];
        state_next     = blk_end ? blk_exit : hpsdr_pkg::RX1;
      end

      hpsdr_pkg::RX1: begin
        byte_no_next   = byte_no - 11'd1;
        round_len_next = round_len + 9'd1;
        data_next      = us_tdata[15:8];
        state_next     = blk_end ? blk_exit : hpsdr_pkg::RX0;
      end

      // Low byte goes out and the word is popped
      hpsdr_pkg::RX0: begin
        byte_no_next   = byte_no - 11'd1;
        round_len_next = round_len + 9'd1;
        data_next      = us_tdata[7:0];
        if (blk_end) begin
          state_next = blk_exit;
        end else begin
          state_next = us_tlast ? hpsdr_pkg::MIC1 : hpsdr_pkg::RX2;
        end
      end

      hpsdr_pkg::MIC1: begin
        byte_no_next   = byte_no - 11'd1;
        round_len_next = round_len + 9'd1;
        data_next      = 8'h00;
        state_next     = blk_end ? blk_exit : hpsdr_pkg::MIC0;
      end

      hpsdr_pkg::MIC0: begin
        byte_no_next   = byte_no - 11'd1;
        round_len_next = '0;
        data_next      = 8'h00;
        if (blk_end) begin
          state_next = blk_exit;
        end else if (byte_no[8:0] > round_len + 9'd1) begin
          // Room left for a round of the same length
          state_next = hpsdr_pkg::RX2;
        end else begin
          state_next = hpsdr_pkg::PAD;
        end
      end

      hpsdr_pkg::PAD: begin
        byte_no_next = byte_no - 11'd1;
        data_next    = 8'h00;
        if (blk_end) state_next = blk_exit;
      end

      default: state_next = hpsdr_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    udp_tx_data <= data_next;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= hpsdr_pkg::IDLE;
      byte_no       <= '0;
      udp_tx_length <= '0;
      seq           <= '0;
      round_len     <= '0;
      resp_rqst     <= 1'b0;
      disc_pend     <= 1'b0;
    end else begin
      state         <= state_next;
      byte_no       <= byte_no_next;
      udp_tx_length <= len_next;
      round_len     <= round_len_next;
      resp_rqst     <= resp_rqst_next;
      seq           <= run ? seq_next : '0;
      // Holds a discovery pulse that lands mid-frame
      if (state == hpsdr_pkg::DISC_REQ) begin
        disc_pend <= 1'b0;
      end else if (discovery) begin
        disc_pend <= 1'b1;
      end
    end
  end

  // Last byte of a block comes from the mic bytes or the padding, never mid-round
  a_block_exit: assert property (@(posedge clk) disable iff (!rst_n)
    in_block && blk_end |-> (state == hpsdr_pkg::MIC0 || state == hpsdr_pkg::PAD));

endmodule

// File: verification/tb_hpsdr_upstream.sv
// Testbench for the upstream path, checking every frame against a reference byte model
`timescale 1ns/10ps

module tb_hpsdr_upstream;

  localparam hpsdr_pkg::byte_t NR_VAL     = 8'h02;
  localparam hpsdr_pkg::byte_t SERIAL_VAL = 8'h3c;
  localparam hpsdr_pkg::mac_t  MAC_VAL    = 48'h00_1c_c0_a2_13_5d;
  localparam int FRAME_TMO = 3000;
  localparam int QUIET_CYC = 1500;
  localparam int PUSH_TMO  = 100;

  logic                 clk;
  logic                 rst_n;
  hpsdr_pkg::sample_t   s_tdata;
  logic                 s_tlast;
  logic                 s_tvalid;
  logic                 s_tready;
  hpsdr_pkg::cmd_addr_t cmd_addr;
  hpsdr_pkg::cmd_data_t cmd_data;
  logic                 cmd_rqst;
  logic                 run;
  logic                 have_ip;
  logic                 discovery;
  logic                 idhermeslite;
  hpsdr_pkg::byte_t     m_tdata;
  logic                 m_tvalid;
  logic                 m_tlast;
  logic                 m_tready;

  // Pushed words as {last, sample}, expected frame and response field
  logic [24:0]          model_q [$];
  hpsdr_pkg::byte_t     exp_frame [0:1031];
  hpsdr_pkg::byte_t     rx_buf [0:1031];
  int                   exp_len;
  int                   rx_len;
  logic                 exp_armed;
  hpsdr_pkg::seq_t      exp_seq;
  logic                 resp_ack;
  hpsdr_pkg::cmd_addr_t resp_addr;
  hpsdr_pkg::cmd_data_t resp_data;
  logic [31:0]          lfsr_state;
  int                   err_count;
  int                   test_err_base;
  int                   pass_count;
  int                   fail_count;
  logic                 aborted;

  hpsdr_upstream_top #(
    .NR(NR_VAL), .SERIAL_NO(SERIAL_VAL), .FIFO_AW(10)
  ) u_dut (
    .clk, .rst_n, .s_tdata, .s_tlast, .s_tvalid, .s_tready,
    .cmd_addr, .cmd_data, .cmd_rqst, .run, .have_ip, .discovery, .idhermeslite,
    .mac(MAC_VAL), .m_tdata, .m_tvalid, .m_tlast, .m_tready
  );

  always #10 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic hpsdr_pkg::sample_t next_sample();
    hpsdr_pkg::sample_t w;
    int i;
    w = '0;
    for (i = 0; i < 24; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[22:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic void put_byte(input hpsdr_pkg::byte_t b);
    exp_frame[exp_len] = b;
    exp_len++;
  endfunction

  function automatic void ref_disc_frame(input logic run_v, input logic id_v);
    logic [63:0] tag;
    int i;
    tag = "HERMESLT";
    exp_len = 0;
    put_byte(8'hef);
    put_byte(8'hfe);
    put_byte(run_v ? 8'h03 : 8'h02);
    for (i = 5; i >= 0; i--) put_byte(MAC_VAL[8*i +: 8]);
    put_byte(SERIAL_VAL);
    for (i = 7; i >= 0; i--) put_byte(tag[8*i +: 8]);
    put_byte(NR_VAL);
    while (exp_len < int'(hpsdr_pkg::DISC_LEN)) put_byte(id_v ? 8'h06 : 8'h01);
    exp_armed = 1'b1;
  endfunction

  function automatic void ref_data_frame();
    logic [39:0] resp_v;
    logic [24:0] w;
    int blk;
    int i;
    int left;
    int len;
    exp_len = 0;
    put_byte(8'hef);
    put_byte(8'hfe);
    put_byte(8'h01);
    put_byte(8'h06);
    for (i = 3; i >= 0; i--) put_byte(exp_seq[8*i +: 8]);
    for (blk = 0; blk < 2; blk++) begin
      // Ack only in the first field after a command
      resp_v = {resp_ack && (blk == 0), 1'b0, resp_addr, resp_data};
      repeat (3) put_byte(8'h7f);
      for (i = 4; i >= 0; i--) put_byte(resp_v[8*i +: 8]);
      left = int'(hpsdr_pkg::BLOCK_LEN) - 8;
      do begin
        len = 0;
        do begin
          w = model_q.pop_front();
          put_byte(w[23:16]);
          put_byte(w[15:8]);
          put_byte(w[7:0]);
          len += 3;
        end while (!w[24]);
        put_byte(8'h00);
        put_byte(8'h00);
        len += 2;
        left -= len;
      end while (left > len);
      repeat (left) put_byte(8'h00);
    end
    exp_seq++;
    resp_ack = 1'b0;
    exp_armed = 1'b1;
  endfunction

  function automatic void compare_frame();
    int i;
    if (!exp_armed) begin
      $display("ERROR at %0t: frame of %0d bytes arrived with none expected", $time, rx_len);
      err_count++;
      return;
    end
    if (rx_len != exp_len) begin
      $display("ERROR at %0t: frame length %0d, expected %0d", $time, rx_len, exp_len);
      err_count++;
    end
    for (i = 0; i < exp_len && i < rx_len; i++) begin
      if (rx_buf[i] !== exp_frame[i]) begin
        $display("ERROR at %0t: byte %0d is %02h, expected %02h",
                 $time, i, rx_buf[i], exp_frame[i]);
        err_count++;
      end
    end
    exp_armed = 1'b0;
  endfunction

  // Bytes sampled on the falling edge
  always @(negedge clk) begin
    if (rst_n && m_tvalid) begin
      if (rx_len < 1032) rx_buf[rx_len] = m_tdata;
      rx_len++;
      if (m_tlast) begin
        compare_frame();
        rx_len = 0;
      end
    end else if (rst_n && rx_len != 0) begin
      $display("ERROR at %0t: m_tvalid dropped after %0d bytes of a frame", $time, rx_len);
      err_count++;
      rx_len = 0;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic push_words(input int n, input logic build_exp);
    logic [24:0] fresh [$];
    int i;
    int tmo;
    for (i = 0; i < n; i++) begin
      fresh.push_back({1'b1, next_sample()});
      model_q.push_back(fresh[i]);
    end
    if (build_exp) ref_data_frame();
    next_cycle();
    for (i = 0; i < n; i++) begin
      s_tdata  = fresh[i][23:0];
      s_tlast  = fresh[i][24];
      s_tvalid = 1'b1;
      tmo = 0;
      while (!s_tready && tmo < PUSH_TMO) begin
        next_cycle();
        tmo++;
      end
      if (!s_tready) begin
        $display("Sample FIFO never became ready, word %0d was not accepted", i);
        err_count++;
        aborted = 1'b1;
        break;
      end
      next_cycle();
    end
    s_tvalid = 1'b0;
  endtask

  task automatic wait_frame();
    int tmo;
    if (aborted) return;
    tmo = 0;
    while (exp_armed && tmo < FRAME_TMO) begin
      @(negedge clk);
      tmo++;
    end
    if (exp_armed) begin
      $display("Timeout: the expected frame did not finish within %0d cycles", FRAME_TMO);
      err_count++;
      aborted = 1'b1;
    end
  endtask

  task automatic expect_quiet(input int cycles);
    int i;
    for (i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (m_tvalid) begin
        $display("ERROR at %0t: m_tvalid rose while no frame may start", $time);
        err_count++;
        break;
      end
    end
  endtask

  task automatic pulse_discovery();
    next_cycle();
    discovery = 1'b1;
    next_cycle();
    discovery = 1'b0;
  endtask

  task automatic send_command(input hpsdr_pkg::cmd_addr_t a, input hpsdr_pkg::cmd_data_t d);
    next_cycle();
    cmd_addr = a;
    cmd_data = d;
    cmd_rqst = 1'b1;
    next_cycle();
    cmd_rqst = 1'b0;
    resp_ack  = 1'b1;
    resp_addr = a;
    resp_data = d;
  endtask

  task automatic open_test();
    test_err_base = err_count;
  endtask

  task automatic close_test(input string name);
    if (err_count == test_err_base) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      fail_count++;
      $display("test %s: %0d errors", name, err_count - test_err_base);
    end
  endtask

  task automatic run_tests();
    open_test();
    if (m_tvalid !== 1'b0 || m_tlast !== 1'b0 || s_tready !== 1'b1) begin
      $display("ERROR at %0t: after reset m_tvalid=%b m_tlast=%b s_tready=%b",
               $time, m_tvalid, m_tlast, s_tready);
      err_count++;
    end
    close_test("reset_state");

    open_test();
    ref_disc_frame(1'b0, 1'b0);
    pulse_discovery();
    wait_frame();
    next_cycle();
    run = 1'b1;
    idhermeslite = 1'b1;
    ref_disc_frame(1'b1, 1'b1);
    pulse_discovery();
    wait_frame();
    next_cycle();
    run = 1'b0;
    idhermeslite = 1'b0;
    close_test("discovery");
    if (aborted) return;

    open_test();
    run = 1'b1;
    have_ip = 1'b1;
    push_words(340, 1'b1);
    wait_frame();
    close_test("data_layout");
    if (aborted) return;

    open_test();
    push_words(200, 1'b1);
    wait_frame();
    push_words(200, 1'b1);
    wait_frame();
    next_cycle();
    run = 1'b0;
    exp_seq = '0;
    repeat (5) next_cycle();
    run = 1'b1;
    push_words(200, 1'b1);
    wait_frame();
    close_test("sequence");
    if (aborted) return;

    open_test();
    send_command(6'h15, 32'hdead_beef);
    push_words(200, 1'b1);
    wait_frame();
    close_test("command_echo");
    if (aborted) return;

    open_test();
    next_cycle();
    have_ip = 1'b0;
    push_words(200, 1'b0);
    expect_quiet(QUIET_CYC);
    ref_data_frame();
    next_cycle();
    have_ip = 1'b1;
    wait_frame();
    // Fill of 334 sits on the threshold without passing it
    push_words(194, 1'b0);
    expect_quiet(QUIET_CYC);
    push_words(1, 1'b1);
    wait_frame();
    close_test("start_conditions");
    if (aborted) return;

    open_test();
    next_cycle();
    m_tready = 1'b0;
    push_words(200, 1'b1);
    expect_quiet(300);
    next_cycle();
    m_tready = 1'b1;
    wait_frame();
    close_test("backpressure");
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    s_tdata       = '0;
    s_tlast       = 1'b0;
    s_tvalid      = 1'b0;
    cmd_addr      = '0;
    cmd_data      = '0;
    cmd_rqst      = 1'b0;
    run           = 1'b0;
    have_ip       = 1'b0;
    discovery     = 1'b0;
    idhermeslite  = 1'b0;
    m_tready      = 1'b1;
    lfsr_state    = 32'haa87;
    exp_len       = 0;
    rx_len        = 0;
    exp_armed     = 1'b0;
    exp_seq       = '0;
    resp_ack      = 1'b0;
    resp_addr     = '0;
    resp_data     = '0;
    err_count     = 0;
    test_err_base = 0;
    pass_count    = 0;
    fail_count    = 0;
    aborted       = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    run_tests();
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && !aborted) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
